/* rtl/emesh_pkg.sv */
`default_nettype none

// mesh transaction format as seen by the receive path
//
// bit layout of the 104-bit packet, low to high:
//   [7:0]     control byte, write flag at bit 1
//   [39:8]    destination address
//   [103:40]  data and source address, passed through untouched
package emesh_pkg;

   // whole packet
   localparam int pw = 104;

   // address field
   localparam int aw       = 32;
   localparam int addr_lsb = 8;
   localparam int addr_msb = addr_lsb + aw - 1;   // 39

   // control byte
   localparam int write_bit = 1;   // set = write, clear = read
   localparam int ctrl_msb  = 7;   // top of low control byte

endpackage : emesh_pkg

`default_nettype wire

/* rtl/erx_cfg_pkg.sv */
`default_nettype none

// receive side configuration: link identity, remap modes, register map
package erx_cfg_pkg;

   // identity of this link in the mesh
   localparam logic [11:0] link_id   = 12'h808;
   localparam logic [5:0]  col_id    = link_id[5:0];   // column number
   localparam int          col_shift = $clog2(col_id);  // 3 for column 8

   // remap mode encodings, 11 is reserved
   localparam logic [1:0] mode_none    = 2'b00;
   localparam logic [1:0] mode_static  = 2'b01;
   localparam logic [1:0] mode_dynamic = 2'b10;

   // register offsets on the config port
   localparam logic [1:0] reg_mode    = 2'd0;
   localparam logic [1:0] reg_sel     = 2'd1;
   localparam logic [1:0] reg_pattern = 2'd2;
   localparam logic [1:0] reg_base    = 2'd3;

endpackage : erx_cfg_pkg

`default_nettype wire

/* rtl/erx_cfg.sv */
`default_nettype none

// remap configuration registers
// written one word at a time, read back combinationally
module erx_cfg (
   input  logic        clk,
   input  logic        reset,
   // register port
   input  logic        cfg_write,
   input  logic [1:0]  cfg_addr,
   input  logic [31:0] cfg_wdata,
   output logic [31:0] cfg_rdata,
   // levels to the remap stage
   output logic [1:0]  remap_mode,
   output logic [11:0] remap_sel,
   output logic [11:0] remap_pattern,
   output logic [31:0] remap_base
);

   // register writes, only the low bits of each field are kept
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         remap_mode    <= 2'b00;   // mode none
         remap_sel     <= 12'h000;
         remap_pattern <= 12'h000;
         remap_base    <= 32'h0000_0000;
      end else if (cfg_write) begin
         case (cfg_addr)
            erx_cfg_pkg::reg_mode:    remap_mode    <= cfg_wdata[1:0];
            erx_cfg_pkg::reg_sel:     remap_sel     <= cfg_wdata[11:0];
            erx_cfg_pkg::reg_pattern: remap_pattern <= cfg_wdata[11:0];
            erx_cfg_pkg::reg_base:    remap_base    <= cfg_wdata;
            default: ;
         endcase
      end
   end

   // readback, zero extended
   always_comb begin
      case (cfg_addr)
         erx_cfg_pkg::reg_mode:    cfg_rdata = {30'b0, remap_mode};
         erx_cfg_pkg::reg_sel:     cfg_rdata = {20'b0, remap_sel};
         erx_cfg_pkg::reg_pattern: cfg_rdata = {20'b0, remap_pattern};
         erx_cfg_pkg::reg_base:    cfg_rdata = remap_base;
         default:                  cfg_rdata = 32'h0000_0000;
      endcase
   end

   // the remap stage has no meaning for mode 11, so it must never be held
   a_no_reserved_mode : assert property (
      @(posedge clk) disable iff (reset)
      (cfg_write && cfg_addr == erx_cfg_pkg::reg_mode)
         |=> (remap_mode != 2'b11)
   ) else $error("reserved remap mode 11 stored");

endmodule : erx_cfg

`default_nettype wire

/* rtl/erx_remap.sv */
`default_nettype none

// destination address remap, one register stage
module erx_remap (
   input  logic                      clk,
   input  logic                      reset,
   // incoming mesh traffic
   input  logic                      access_in,
   input  logic [emesh_pkg::pw-1:0]  packet_in,
   // configuration levels
   input  logic [1:0]                remap_mode,
   input  logic [11:0]               remap_sel,
   input  logic [11:0]               remap_pattern,
   input  logic [31:0]               remap_base,
   // remapped traffic
   output logic                      access_out,
   output logic [emesh_pkg::pw-1:0]  packet_out
);

   logic [emesh_pkg::aw-1:0] addr_in;
   logic [emesh_pkg::aw-1:0] static_addr;
   logic [emesh_pkg::aw-1:0] dynamic_addr;
   logic [emesh_pkg::aw-1:0] remap_addr;
   logic [emesh_pkg::aw-1:0] col_offset;
   logic [emesh_pkg::aw-1:0] top_offset;

   assign addr_in = packet_in[emesh_pkg::addr_msb:emesh_pkg::addr_lsb];

   // static: pattern bits replace the address where sel is set
   assign static_addr = {(remap_sel & remap_pattern) |
                         (~remap_sel & addr_in[emesh_pkg::aw-1:emesh_pkg::aw-12]),
                         addr_in[emesh_pkg::aw-13:0]};

   // continuity: squeeze per-link windows into one range starting at base
   assign col_offset = emesh_pkg::aw'(erx_cfg_pkg::col_id) << 20;   // this link's window
   assign top_offset = emesh_pkg::aw'(addr_in[emesh_pkg::aw-1:emesh_pkg::aw-6])
                       << erx_cfg_pkg::col_shift;
   assign dynamic_addr = addr_in - col_offset + remap_base - top_offset;   // wraps mod 2^32

   always_comb begin
      case (remap_mode)
         erx_cfg_pkg::mode_static:  remap_addr = static_addr;
         erx_cfg_pkg::mode_dynamic: remap_addr = dynamic_addr;
         default:                   remap_addr = addr_in;   // none, reserved
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         access_out <= 1'b0;
      else
         access_out <= access_in;
   end

   // payload, no reset
   always_ff @(posedge clk) begin
      packet_out <= {packet_in[emesh_pkg::pw-1:emesh_pkg::addr_msb+1],
                     remap_addr,
                     packet_in[emesh_pkg::ctrl_msb:0]};
   end

   // nothing stalls, so every strobe leaves exactly one cycle later
   a_one_cycle : assert property (
      @(posedge clk) disable iff (reset)
      !$past(reset) |-> (access_out == $past(access_in))
   ) else $error("remap strobe not delayed by one cycle");

endmodule : erx_remap

`default_nettype wire

/* rtl/erx_disty.sv */
`default_nettype none

// steers each remapped packet to the write or the read output
module erx_disty (
   input  logic                      clk,
   input  logic                      reset,
   // from remap
   input  logic                      access_in,
   input  logic [emesh_pkg::pw-1:0]  packet_in,
   // write side
   output logic                      wr_access,
   output logic [emesh_pkg::pw-1:0]  wr_packet,
   // read side
   output logic                      rd_access,
   output logic [emesh_pkg::pw-1:0]  rd_packet
);

   logic is_write;

   assign is_write = packet_in[emesh_pkg::write_bit];

   // one strobe per packet, on the side given by the write flag
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_access <= 1'b0;
         rd_access <= 1'b0;
      end else begin
         wr_access <= access_in & is_write;
         rd_access <= access_in & ~is_write;
      end
   end

   // only the selected side is loaded, the other keeps its last packet
   always_ff @(posedge clk) begin
      if (access_in) begin
         if (is_write)
            wr_packet <= packet_in;
         else
            rd_packet <= packet_in;
      end
   end

   a_one_side : assert property (
      @(posedge clk) disable iff (reset)
      !(wr_access && rd_access)
   ) else $error("write and read strobes high together");

endmodule : erx_disty

`default_nettype wire

/* rtl/erx_core.sv */
`default_nettype none

// receive core: config registers, address remap, write/read split
// two cycles from access_in to wr_access or rd_access
module erx_core (
   input  logic                      clk,
   input  logic                      reset,
   // configuration port
   input  logic                      cfg_write,
   input  logic [1:0]                cfg_addr,
   input  logic [31:0]               cfg_wdata,
   output logic [31:0]               cfg_rdata,
   // inbound traffic
   input  logic                      access_in,
   input  logic [emesh_pkg::pw-1:0]  packet_in,
   // outputs
   output logic                      wr_access,
   output logic [emesh_pkg::pw-1:0]  wr_packet,
   output logic                      rd_access,
   output logic [emesh_pkg::pw-1:0]  rd_packet
);

   logic [1:0]                remap_mode;
   logic [11:0]               remap_sel;
   logic [11:0]               remap_pattern;
   logic [31:0]               remap_base;
   logic                      remap_access;
   logic [emesh_pkg::pw-1:0]  remap_packet;

   erx_cfg u_cfg (
      .clk           (clk),
      .reset         (reset),
      .cfg_write     (cfg_write),
      .cfg_addr      (cfg_addr),
      .cfg_wdata     (cfg_wdata),
      .cfg_rdata     (cfg_rdata),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base)
   );

   erx_remap u_remap (
      .clk           (clk),
      .reset         (reset),
      .access_in     (access_in),
      .packet_in     (packet_in),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base),
      .access_out    (remap_access),
      .packet_out    (remap_packet)
   );

   erx_disty u_disty (
      .clk       (clk),
      .reset     (reset),
      .access_in (remap_access),
      .packet_in (remap_packet),
      .wr_access (wr_access),
      .wr_packet (wr_packet),
      .rd_access (rd_access),
      .rd_packet (rd_packet)
   );

endmodule : erx_core

`default_nettype wire

/* dv/erx_core_tb.sv */
`default_nettype none

// file-driven testbench for the receive core
// one golden line per operation, inputs driven on the falling edge
module erx_core_tb;

   logic                      clk;
   logic                      reset;
   logic                      cfg_write;
   logic [1:0]                cfg_addr;
   logic [31:0]               cfg_wdata;
   logic [31:0]               cfg_rdata;
   logic                      access_in;
   logic [emesh_pkg::pw-1:0]  packet_in;
   logic                      wr_access;
   logic [emesh_pkg::pw-1:0]  wr_packet;
   logic                      rd_access;
   logic [emesh_pkg::pw-1:0]  rd_packet;

   int cycles = 0;        // rising edges seen so far
   int errors = 0;
   int tests = 0;
   int tests_failed = 0;
   bit timed_out = 1'b0;

   // packets in flight, oldest first
   bit                        exp_wr_q[$];
   logic [emesh_pkg::pw-1:0]  exp_pkt_q[$];
   int                        exp_cyc_q[$];

   erx_core DUT (
      .clk       (clk),
      .reset     (reset),
      .cfg_write (cfg_write),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .access_in (access_in),
      .packet_in (packet_in),
      .wr_access (wr_access),
      .wr_packet (wr_packet),
      .rd_access (rd_access),
      .rd_packet (rd_packet)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cycles <= cycles + 1;

   // compare any strobe from the last rising edge with the oldest expected packet
   task automatic check_outputs();
      bit                        exp_wr;
      logic [emesh_pkg::pw-1:0]  exp_pkt;
      logic [emesh_pkg::pw-1:0]  got;
      int                        entered;
      if (wr_access && rd_access) begin
         $display("write and read strobes both high at %0t", $time);
         errors++;
      end else if (wr_access || rd_access) begin
         if (exp_wr_q.size() == 0) begin
            $display("packet came out at %0t with none expected", $time);
            errors++;
         end else begin
            exp_wr = exp_wr_q.pop_front();
            exp_pkt = exp_pkt_q.pop_front();
            entered = exp_cyc_q.pop_front();
            got = exp_wr ? wr_packet : rd_packet;
            if (wr_access != exp_wr) begin
               $display("error at %0t: wr_access expected %0d got %0d",
                        $time, exp_wr, wr_access);
               errors++;
            end else if (got !== exp_pkt) begin
               $display("error at %0t: %s expected %h got %h", $time,
                        exp_wr ? "wr_packet" : "rd_packet", exp_pkt, got);
               errors++;
            end
            // two register stages, remap then distribution
            if (cycles - entered != 2) begin
               $display("error at %0t: latency expected 2 got %0d", $time, cycles - entered);
               errors++;
            end
         end
      end
   endtask

   task automatic step_cycle();
      @(negedge clk);
      check_outputs();
      access_in = 1'b0;   // strobes last one cycle
      cfg_write = 1'b0;
   endtask

   task automatic drain_outputs(output bit ok);
      int waited;
      waited = 0;
      while (exp_wr_q.size() != 0 && waited < 20) begin
         step_cycle();
         waited++;
      end
      ok = (exp_wr_q.size() == 0);
      if (!ok)
         $display("timeout at %0t: %0d packets never came out", $time, exp_wr_q.size());
   endtask

   initial begin
      int                        fd;
      int                        n;
      int                        errors_before;
      string                     line;
      string                     op;
      string                     name;
      string                     side;
      logic [31:0]               arg;
      logic [31:0]               value;
      logic [emesh_pkg::pw-1:0]  pkt;
      logic [emesh_pkg::pw-1:0]  exp_pkt;
      bit                        ok;

      reset = 1'b1;
      cfg_write = 1'b0;
      cfg_addr = 2'd0;
      cfg_wdata = 32'h0;
      access_in = 1'b0;
      packet_in = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      errors_before = 0;
      fd = $fopen("dv/erx_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open dv/erx_golden.txt");
         errors++;
      end else begin
         while (!timed_out && $fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", op);
            if (n < 1 || op.getc(0) == "#")
               continue;   // blank or comment
            if (op == "cfg") begin
               n = $sscanf(line, "%s %h %h", op, arg, value);
               cfg_write = 1'b1;
               cfg_addr = arg[1:0];
               cfg_wdata = value;
               step_cycle();
            end else if (op == "rd") begin
               n = $sscanf(line, "%s %h %h", op, arg, value);
               cfg_addr = arg[1:0];
               step_cycle();
               if (cfg_rdata !== value) begin
                  $display("error at %0t: cfg_rdata expected %h got %h", $time, value, cfg_rdata);
                  errors++;
               end
            end else if (op == "pkt") begin
               n = $sscanf(line, "%s %h %s %h", op, pkt, side, exp_pkt);
               if (side != "w" && side != "r") begin
                  $display("golden packet line has side %s, not w or r", side);
                  errors++;
               end
               exp_wr_q.push_back(side == "w");
               exp_pkt_q.push_back(exp_pkt);
               exp_cyc_q.push_back(cycles);
               access_in = 1'b1;
               packet_in = pkt;
               step_cycle();
            end else if (op == "end") begin
               n = $sscanf(line, "%s %s", op, name);
               drain_outputs(ok);
               if (!ok) begin
                  errors++;
                  timed_out = 1'b1;
               end
               tests++;
               if (errors == errors_before) begin
                  $display("test %s: pass", name);
               end else begin
                  tests_failed++;
                  $display("test %s: fail with %0d errors", name, errors - errors_before);
               end
               errors_before = errors;
            end else begin
               $display("unknown operation %s in golden file", op);
               errors++;
            end
         end
         $fclose(fd);
         if (!timed_out) begin
            drain_outputs(ok);   // packets after the last test marker
            if (!ok)
               errors++;
         end
      end

      if (tests == 0) begin
         $display("no tests found in golden file");
         errors++;
      end
      $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule : erx_core_tb

`default_nettype wire

/* dv/erx_golden.txt */
# cfg <offset> <data> | rd <offset> <expected data> | end <test name>
# pkt <packet 26 hex: data 16, address 8, ctrl 2> <side w or r> <expected packet>
rd 0 00000000
rd 1 00000000
rd 2 00000000
rd 3 00000000
pkt 11112222333344448081234502 w 11112222333344448081234502
pkt 55556666777788880000abcd05 r 55556666777788880000abcd05
end reset_defaults
cfg 0 fffffffe
rd 0 00000002
cfg 1 abcdef12
rd 1 00000f12
cfg 2 12345678
rd 2 00000678
cfg 3 deadbeef
rd 3 deadbeef
cfg 0 00000001
rd 0 00000001
end reg_readback
cfg 1 00000ff0
cfg 2 00000a50
pkt cafef00d123456788081234503 w cafef00d12345678a581234503
pkt 0102030405060708123fffff00 r 0102030405060708a53fffff00
pkt fffffffffffffffffffabcde01 r ffffffffffffffffa5fabcde01
end static_mode
cfg 0 00000002
cfg 3 40000000
pkt 00000000000000018081234502 w 0000000000000001c001224502
pkt 0000000000000002808fffff00 r 0000000000000002c00ffeff00
pkt 0000000000000003000000100a w 00000000000000033f8000100a
pkt 0000000000000004fc00000004 r 00000000000000043b7ffe0804
end continuity_mode
cfg 0 00000000
pkt 00000000000000011000000002 w 00000000000000011000000002
pkt 00000000000000022000000000 r 00000000000000022000000000
pkt 00000000000000033000000006 w 00000000000000033000000006
pkt 00000000000000044000000001 r 00000000000000044000000001
end back_to_back
cfg 1 00000fff
cfg 2 00000123
pkt 00000000deadbeefabc4567802 w 00000000deadbeefabc4567802
cfg 0 00000001
pkt 00000000deadbeefabc4567800 r 00000000deadbeef1234567800
rd 0 00000001
end mode_change

/* build.f */
rtl/emesh_pkg.sv
rtl/erx_cfg_pkg.sv
rtl/erx_cfg.sv
rtl/erx_remap.sv
rtl/erx_disty.sv
rtl/erx_core.sv
dv/erx_core_tb.sv

/* Makefile */
# Verilator build and run of the erx_core testbench
# override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= erx_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TB PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
